// File: bench/sram_model.sv
`timescale 1ns/1ps
`include "sram_test_defines.svh"

module sram_model (
    input  logic [`SRAM_ADDR_WIDTH-1:0] sram_a,
    inout  wire  [15:0]                 sram_io,
    input  logic                        sram_bhe_b,
    input  logic                        sram_ble_b,
    input  logic                        sram_ce1_b,
    input  logic                        sram_oe_b,
    input  logic                        sram_we_b
);

    logic [15:0] mem [bit [`SRAM_ADDR_WIDTH-1:0]];   // only touched halfwords exist
    logic [15:0] rd_data;
    logic [15:0] word;

    assign sram_io = (!sram_ce1_b && !sram_oe_b && sram_we_b) ? rd_data : 16'hzzzz;

    always @(sram_a or sram_ce1_b or sram_oe_b or sram_we_b) begin
        rd_data = mem.exists(sram_a) ? mem[sram_a] : 16'hxxxx;
    end

    // the write lands once the pins have settled after a clock edge
    always @(sram_a or sram_io or sram_we_b or sram_ce1_b or sram_ble_b or sram_bhe_b) begin
        #1;
        if (!sram_ce1_b && !sram_we_b) begin
            word = mem.exists(sram_a) ? mem[sram_a] : 16'hxxxx;
            if (!sram_ble_b)
                word[7:0] = sram_io[7:0];
            if (!sram_bhe_b)
                word[15:8] = sram_io[15:8];
            mem[sram_a] = word;
        end
    end

endmodule

// File: bench/tb_sram_test.sv
`timescale 1ns/1ps
`include "sram_test_defines.svh"

module tb_sram_test;

    localparam int CLK_PERIOD_NS = 20;
    localparam int RUN_CYCLES    = 10000;   // all six tests need well under a quarter of this

    logic                        BUS_CLK;
    logic                        BUS_RST;
    logic [15:0]                 bus_add;
    logic [7:0]                  bus_data_in;
    logic [7:0]                  bus_data_out;
    logic                        bus_rd;
    logic                        bus_wr;
    logic                        fread;
    logic                        fstrobe;
    logic [7:0]                  fd;
    logic                        fifo_not_empty;
    logic [`SRAM_ADDR_WIDTH-1:0] sram_a;
    wire  [15:0]                 sram_io;
    logic                        sram_bhe_b;
    logic                        sram_ble_b;
    logic                        sram_ce1_b;
    logic                        sram_oe_b;
    logic                        sram_we_b;

    integer      seed;
    logic [31:0] next_cnt;     // index of the next counter word expected
    logic [7:0]  host_reads;   // every fread and fstrobe pair, modulo 256
    logic [7:0]  exp_bytes[$];

    sram_test DUT (.*);

    sram_model i_sram (.*);

    always #(CLK_PERIOD_NS / 2) BUS_CLK = ~BUS_CLK;

    // ####################################################################
    // helpers
    // ####################################################################

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string test_name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else
            report_failure($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h",
                                     test_name, exp, act));
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // bytes 4c to 4c+3, least significant first
    function automatic logic [31:0] counter_word(input logic [31:0] idx);
        logic [31:0] w;
        for (int i = 0; i < 4; i++)
            w[8*i +: 8] = 8'(4 * idx + i);
        return w;
    endfunction

    task automatic push_word(input logic [31:0] w);
        for (int i = 0; i < 4; i++)
            exp_bytes.push_back(w[8*i +: 8]);
    endtask

    task automatic next_cycle();
        @(posedge BUS_CLK);
        #2;
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        next_cycle();
        bus_wr = 1'b0;
    endtask

    task automatic read_reg(input logic [15:0] addr, output logic [7:0] data);
        bus_add = addr;
        bus_rd  = 1'b1;
        next_cycle();
        bus_rd = 1'b0;
        data   = bus_data_out;   // latched at the edge just passed
    endtask

    task automatic read_word_count(output logic [23:0] n);
        for (int i = 0; i < 3; i++)
            read_reg(`FIFO_ADDR + i, n[8*i +: 8]);
    endtask

    task automatic load_pattern(input logic [31:0] pat);
        for (int i = 0; i < 4; i++)
            write_reg(`PATTERN_ADDR + i, pat[8*i +: 8]);
    endtask

    // turn both sources off and let a word in flight land
    task automatic stop_sources(output logic [23:0] n);
        write_reg(`CONTROL_ADDR, 8'h00);
        repeat (6) next_cycle();
        read_word_count(n);
    endtask

    task automatic pop_byte(output logic [7:0] b);
        int          waited;
        logic [31:0] r;
        waited = 0;
        while (!fifo_not_empty || rand_below(4) == 0) begin
            r       = $random(seed);
            fread   = r[0];   // fread alone is no read
            fstrobe = 1'b0;
            if (!fifo_not_empty)
                waited++;
            if (waited > 60)
                report_failure("fifo_not_empty did not rise while the FIFO held data");
            next_cycle();
        end
        b          = fd;
        fread      = 1'b1;
        fstrobe    = 1'b1;
        host_reads = host_reads + 8'd1;
        next_cycle();
        fread   = 1'b0;
        fstrobe = 1'b0;
    endtask

    task automatic pop_word(output logic [31:0] w);
        for (int i = 0; i < 4; i++)
            pop_byte(w[8*i +: 8]);
    endtask

    task automatic expect_empty(input string test_name);
        logic [23:0] n;
        repeat (8) next_cycle();
        assert (!fifo_not_empty) else
            report_failure({test_name, ": a byte is still offered after the drain"});
        read_word_count(n);
        check_value(test_name, 32'd0, n);
    endtask

    task automatic drain(input string test_name, input int unsigned n_words);
        logic [7:0] b;
        for (int i = 0; i < 4 * n_words; i++) begin
            pop_byte(b);
            check_value(test_name, exp_bytes.pop_front(), b);
        end
        expect_empty(test_name);
    endtask

    initial begin
        #(CLK_PERIOD_NS * RUN_CYCLES);
        report_failure("watchdog expired before the tests finished");
    end

    // ####################################################################
    // test sequence
    // ####################################################################

    initial begin
        logic [23:0] n;
        logic [31:0] pat;
        logic [31:0] w;
        logic [15:0] addr;
        logic [7:0]  val;
        logic [7:0]  rd;
        logic [31:0] r;
        int          src;
        int          last_src;
        int          k;

        seed        = 32'h43e0a795;
        BUS_CLK     = 1'b0;
        BUS_RST     = 1'b1;
        bus_add     = 16'h0000;
        bus_data_in = 8'h00;
        bus_rd      = 1'b0;
        bus_wr      = 1'b0;
        fread       = 1'b0;
        fstrobe     = 1'b0;
        next_cnt    = 32'd0;
        host_reads  = 8'd0;
        repeat (2) next_cycle();
        BUS_RST = 1'b0;
        assert (sram_we_b && sram_oe_b && sram_ce1_b && !fifo_not_empty) else
            report_failure("SRAM strobes or fifo_not_empty are active after reset");

        // register readback, sources kept off
        for (int i = 0; i < 16; i++) begin
            if (rand_below(2) == 0) begin
                addr = `CONTROL_ADDR;
                val  = $random(seed) & 8'hfc;
            end else begin
                addr = `PATTERN_ADDR + rand_below(4);
                val  = $random(seed);
            end
            write_reg(addr, val);
            read_reg(addr, rd);
            check_value("register_readback", val, rd);
        end
        write_reg(`CONTROL_ADDR, 8'h00);

        write_reg(`CONTROL_ADDR, 8'h01);
        repeat (20 + rand_below(80)) next_cycle();
        stop_sources(n);
        assert (n > 0) else report_failure("counter_stream stored no words");
        for (int i = 0; i < n; i++) begin
            push_word(counter_word(next_cnt));
            next_cnt = next_cnt + 1;
        end
        drain("counter_stream", n);

        pat = $random(seed);
        load_pattern(pat);
        write_reg(`CONTROL_ADDR, 8'h02);
        repeat (20 + rand_below(80)) next_cycle();
        stop_sources(n);
        assert (n > 0) else report_failure("pattern_stream stored no words");
        for (int i = 0; i < n; i++)
            push_word(pat);
        drain("pattern_stream", n);

        pat    = $random(seed);
        pat[0] = 1'b1;   // an odd low byte never starts a counter word
        load_pattern(pat);
        write_reg(`CONTROL_ADDR, 8'h03);
        repeat (20 + rand_below(60)) next_cycle();
        stop_sources(n);
        assert (n >= 2) else report_failure("interleave stored fewer than two words");
        last_src = -1;
        for (int i = 0; i < n; i++) begin
            pop_word(w);
            if (w == counter_word(next_cnt)) begin
                src      = 0;
                next_cnt = next_cnt + 1;
            end else begin
                check_value("interleave", pat, w);
                src = 1;
            end
            assert (src != last_src) else
                report_failure("interleave got two words in a row from one source");
            last_src = src;
        end
        expect_empty("interleave");

        k = 1 + rand_below(6);
        for (int i = 0; i < k; i++) begin
            write_reg(`PULSE_ADDR, $random(seed));
            repeat (10) next_cycle();   // room for the write and the prefetch
            push_word(counter_word(next_cnt));
            next_cnt = next_cnt + 1;
        end
        read_word_count(n);
        check_value("pulse", k, n);
        drain("pulse", k);

        write_reg(`CONTROL_ADDR, 8'h04);
        check_value("direct_mode", host_reads, fd);
        for (int i = 0; i < 300; i++) begin
            r       = $random(seed);
            fread   = r[0];
            fstrobe = r[1];
            if (r[0] && r[1])
                host_reads = host_reads + 8'd1;
            next_cycle();
            check_value("direct_mode", host_reads, fd);
        end
        fread   = 1'b0;
        fstrobe = 1'b0;
        write_reg(`CONTROL_ADDR, 8'h00);

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: flist.f
+incdir+src
src/sram_test_pkg.sv
src/reg_bus_if.sv
src/bus_regs.sv
src/test_counters.sv
src/rr_arbiter.sv
src/sram_fifo.sv
src/sram_test.sv
bench/sram_model.sv
bench/tb_sram_test.sv

// File: src/bus_regs.sv
`timescale 1ns/1ps
`include "sram_test_defines.svh"

module bus_regs (
    input  logic                   BUS_CLK,
    input  logic                   BUS_RST,
    reg_bus_if.target              bus,
    input  logic [23:0]            fifo_words,
    output logic                   counter_en,
    output logic                   pattern_en,
    output logic                   counter_direct,
    output logic [`WORD_WIDTH-1:0] pattern,
    output logic                   pulse
);
    import sram_test_pkg::*;

    localparam logic [15:0] PATTERN_BASE = `PATTERN_ADDR;
    localparam logic [15:0] FIFO_BASE    = `FIFO_ADDR;

    logic [7:0] control;
    logic       sel_control;
    logic       sel_pattern;
    logic       sel_fifo;
    logic       sel_pulse;
    logic [7:0] rd_mux;

    assign sel_control = bus.add == `CONTROL_ADDR;
    assign sel_pattern = bus.add[15:2] == PATTERN_BASE[15:2];
    assign sel_fifo    = bus.add[15:2] == FIFO_BASE[15:2];
    assign sel_pulse   = bus.add == `PULSE_ADDR;

    assign counter_en     = control[0];
    assign pattern_en     = control[1];
    assign counter_direct = control[2];

    // zero for any address this block does not own
    always_comb begin
        rd_mux = 8'h00;
        if (sel_control) begin
            rd_mux = control;
        end else if (sel_pattern) begin
            rd_mux = pattern[{bus.add[1:0], 3'b000} +: 8];
        end else if (sel_fifo) begin
            case (bus.add[1:0])
                2'd0:    rd_mux = fifo_words[7:0];
                2'd1:    rd_mux = fifo_words[15:8];
                2'd2:    rd_mux = fifo_words[23:16];
                default: rd_mux = 8'h00;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            control           <= 8'h00;
            pattern           <= '0;
            pulse             <= 1'b0;
            bus.data_out_regs <= 8'h00;
        end else begin
            pulse <= (bus.op == bus_write) && sel_pulse;
            if (bus.op == bus_write && sel_control)
                control <= bus.data_in;
            if (bus.op == bus_write && sel_pattern)
                pattern[{bus.add[1:0], 3'b000} +: 8] <= bus.data_in;
            if (bus.op == bus_read)
                bus.data_out_regs <= rd_mux;   // held until the next read
        end
    end

endmodule

// File: src/reg_bus_if.sv
`timescale 1ns/1ps

interface reg_bus_if;
    import sram_test_pkg::*;

    logic [15:0] add;
    logic [7:0]  data_in;
    logic [7:0]  data_out_regs;   // read lane of the register block
    logic [7:0]  data_out_fifo;   // read lane of the FIFO
    bus_op_e     op;

    modport controller (
        output add, data_in, op,
        input  data_out_regs, data_out_fifo
    );

    // a target only drives its own lane
    modport target (
        input  add, data_in, op,
        output data_out_regs, data_out_fifo
    );

endinterface

// File: src/rr_arbiter.sv
`timescale 1ns/1ps
`include "sram_test_defines.svh"

module rr_arbiter (
    input  logic                   BUS_CLK,
    input  logic                   BUS_RST,
    input  logic                   cnt_req,
    input  logic [`WORD_WIDTH-1:0] cnt_data,
    input  logic                   pattern_req,
    input  logic [`WORD_WIDTH-1:0] pattern,
    input  logic                   fifo_ready,
    output logic                   cnt_grant,
    output logic                   pattern_grant,
    output logic                   fifo_write,
    output logic [`WORD_WIDTH-1:0] fifo_data
);
    import sram_test_pkg::*;

    arb_owner_e last_owner;
    logic       pick_cnt;

    // on a tie the source that did not win last time goes first
    assign pick_cnt = cnt_req && (!pattern_req || last_owner == pattern_src);

    assign cnt_grant     = fifo_ready && pick_cnt;
    assign pattern_grant = fifo_ready && pattern_req && !pick_cnt;
    assign fifo_write    = cnt_grant || pattern_grant;
    assign fifo_data     = pick_cnt ? cnt_data : pattern;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            last_owner <= pattern_src;   // counter wins the first tie
        end else if (cnt_grant) begin
            last_owner <= counter_src;
        end else if (pattern_grant) begin
            last_owner <= pattern_src;
        end
    end

endmodule

// File: src/sram_fifo.sv
`timescale 1ns/1ps
`include "sram_test_defines.svh"

module sram_fifo (
    input  logic                        BUS_CLK,
    input  logic                        BUS_RST,
    reg_bus_if.target                   bus,
    input  logic                        fifo_write,
    input  logic [`WORD_WIDTH-1:0]      fifo_data,
    output logic                        fifo_ready,
    input  logic                        usb_read,
    output logic [7:0]                  usb_data,
    output logic                        fifo_not_empty,
    output logic [23:0]                 fifo_words,
    output logic [`SRAM_ADDR_WIDTH-1:0] sram_a,
    inout  wire  [15:0]                 sram_io,
    output logic                        sram_bhe_b,
    output logic                        sram_ble_b,
    output logic                        sram_ce1_b,
    output logic                        sram_oe_b,
    output logic                        sram_we_b
);
    import sram_test_pkg::*;

    localparam int unsigned HW_DEPTH = 1 << `SRAM_ADDR_WIDTH;

    fifo_state_e                 state;
    logic                        started;
    logic [`SRAM_ADDR_WIDTH-1:0] wr_ptr;
    logic [`SRAM_ADDR_WIDTH-1:0] rd_ptr;
    logic [`SRAM_ADDR_WIDTH:0]   hw_count;   // halfwords held in the SRAM
    logic [23:0]                 word_cnt;
    logic [`WORD_WIDTH-1:0]      wr_word;
    logic [15:0]                 hold_data;
    logic                        hold_valid;
    logic                        hold_sel;   // high byte is next
    logic                        hold_hi;    // holder carries the upper half of a word
    logic                        sram_full;
    logic                        start_read;
    logic                        byte_taken;
    logic                        word_done;
    logic                        writing;
    logic                        reading;

    // no readable registers here, the lane stays quiet
    assign bus.data_out_fifo = 8'h00;

    // a word needs two free halfwords
    assign sram_full  = hw_count >= HW_DEPTH - 1;
    assign start_read = !hold_valid && (hw_count != '0);
    assign writing    = (state == write_lo) || (state == write_hi);
    assign reading    = (state == read_fetch) || (state == read_latch);
    assign fifo_ready = started && (state == idle) && !start_read && !sram_full;

    assign byte_taken = usb_read && hold_valid;
    assign word_done  = byte_taken && hold_sel && hold_hi;

    // ####################################################################
    // SRAM pins
    // ####################################################################

    assign sram_ce1_b = !(writing || reading);
    assign sram_bhe_b = sram_ce1_b;
    assign sram_ble_b = sram_ce1_b;
    assign sram_we_b  = !writing;
    assign sram_oe_b  = !reading;
    assign sram_a     = reading ? rd_ptr : wr_ptr;
    assign sram_io    = !writing ? 16'hzzzz :
                        (state == write_hi) ? wr_word[31:16] : wr_word[15:0];

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            state    <= idle;
            started  <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            hw_count <= '0;
        end else begin
            started <= 1'b1;
            case (state)
                idle: begin
                    if (start_read)
                        state <= read_fetch;   // refill the holder before taking writes
                    else if (fifo_ready && fifo_write)
                        state <= write_lo;
                end
                write_lo, write_hi: begin
                    wr_ptr   <= wr_ptr + 1'b1;
                    hw_count <= hw_count + 1'b1;
                    state    <= (state == write_lo) ? write_hi : idle;
                end
                read_fetch: state <= read_latch;
                read_latch: begin
                    rd_ptr   <= rd_ptr + 1'b1;
                    hw_count <= hw_count - 1'b1;
                    state    <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (state == idle && fifo_write)
            wr_word <= fifo_data;
        if (state == read_latch) begin
            hold_data <= sram_io;
            hold_hi   <= rd_ptr[0];   // odd addresses hold the upper halves
        end
    end

    // ####################################################################
    // byte holder and word count
    // ####################################################################

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            hold_valid <= 1'b0;
            hold_sel   <= 1'b0;
            word_cnt   <= '0;
        end else begin
            if (state == read_latch) begin
                hold_valid <= 1'b1;
                hold_sel   <= 1'b0;
            end else if (byte_taken) begin
                if (hold_sel)
                    hold_valid <= 1'b0;
                hold_sel <= !hold_sel;
            end
            case ({state == write_hi, word_done})
                2'b10:   word_cnt <= word_cnt + 24'd1;
                2'b01:   word_cnt <= word_cnt - 24'd1;
                default: word_cnt <= word_cnt;
            endcase
        end
    end

    assign usb_data       = hold_sel ? hold_data[15:8] : hold_data[7:0];
    assign fifo_not_empty = hold_valid;
    assign fifo_words     = word_cnt;

endmodule

// File: src/sram_test.sv
`timescale 1ns/1ps
`include "sram_test_defines.svh"

module sram_test (
    input  logic                        BUS_CLK,
    input  logic                        BUS_RST,
    input  logic [15:0]                 bus_add,
    input  logic [7:0]                  bus_data_in,
    output logic [7:0]                  bus_data_out,
    input  logic                        bus_rd,
    input  logic                        bus_wr,
    input  logic                        fread,
    input  logic                        fstrobe,
    output logic [7:0]                  fd,
    output logic                        fifo_not_empty,
    output logic [`SRAM_ADDR_WIDTH-1:0] sram_a,
    inout  wire  [15:0]                 sram_io,
    output logic                        sram_bhe_b,
    output logic                        sram_ble_b,
    output logic                        sram_ce1_b,
    output logic                        sram_oe_b,
    output logic                        sram_we_b
);
    import sram_test_pkg::*;

    logic                   usb_read;
    logic                   counter_en;
    logic                   pattern_en;
    logic                   counter_direct;
    logic                   pulse;
    logic [`WORD_WIDTH-1:0] pattern;
    logic [`WORD_WIDTH-1:0] cnt_data;
    logic [`WORD_WIDTH-1:0] fifo_data;
    logic                   cnt_req;
    logic                   cnt_grant;
    logic                   fifo_write;
    logic                   fifo_ready;
    logic [7:0]             usb_data;
    logic [23:0]            fifo_words;

    reg_bus_if bus ();

    // write wins when both strobes are up
    assign bus.add     = bus_add;
    assign bus.data_in = bus_data_in;
    always_comb begin
        if (bus_wr)
            bus.op = bus_write;
        else if (bus_rd)
            bus.op = bus_read;
        else
            bus.op = bus_idle;
    end
    assign bus_data_out = bus.data_out_regs | bus.data_out_fifo;

    assign usb_read = fread & fstrobe;

    bus_regs i_bus_regs (
        .BUS_CLK        (BUS_CLK),
        .BUS_RST        (BUS_RST),
        .bus            (bus),
        .fifo_words     (fifo_words),
        .counter_en     (counter_en),
        .pattern_en     (pattern_en),
        .counter_direct (counter_direct),
        .pattern        (pattern),
        .pulse          (pulse)
    );

    test_counters i_test_counters (
        .BUS_CLK        (BUS_CLK),
        .BUS_RST        (BUS_RST),
        .counter_en     (counter_en),
        .pulse          (pulse),
        .cnt_grant      (cnt_grant),
        .usb_read       (usb_read),
        .counter_direct (counter_direct),
        .fifo_byte      (usb_data),
        .cnt_req        (cnt_req),
        .cnt_data       (cnt_data),
        .fd             (fd)
    );

    // the pattern register is a level and has nothing to consume
    rr_arbiter i_rr_arbiter (
        .BUS_CLK       (BUS_CLK),
        .BUS_RST       (BUS_RST),
        .cnt_req       (cnt_req),
        .cnt_data      (cnt_data),
        .pattern_req   (pattern_en),
        .pattern       (pattern),
        .fifo_ready    (fifo_ready),
        .cnt_grant     (cnt_grant),
        .pattern_grant (),
        .fifo_write    (fifo_write),
        .fifo_data     (fifo_data)
    );

    sram_fifo i_sram_fifo (
        .BUS_CLK        (BUS_CLK),
        .BUS_RST        (BUS_RST),
        .bus            (bus),
        .fifo_write     (fifo_write),
        .fifo_data      (fifo_data),
        .fifo_ready     (fifo_ready),
        .usb_read       (usb_read),
        .usb_data       (usb_data),
        .fifo_not_empty (fifo_not_empty),
        .fifo_words     (fifo_words),
        .sram_a         (sram_a),
        .sram_io        (sram_io),
        .sram_bhe_b     (sram_bhe_b),
        .sram_ble_b     (sram_ble_b),
        .sram_ce1_b     (sram_ce1_b),
        .sram_oe_b      (sram_oe_b),
        .sram_we_b      (sram_we_b)
    );

endmodule

// File: src/sram_test_defines.svh
`ifndef SRAM_TEST_DEFINES_SVH
`define SRAM_TEST_DEFINES_SVH

// ####################################################################
// register bus address map
// ####################################################################

// bit 0 counter_en, bit 1 pattern_en, bit 2 counter_direct
`define CONTROL_ADDR 16'h0000
`define PATTERN_ADDR 16'h0010   // four bytes, least significant first
`define FIFO_ADDR    16'h0020   // three read-only bytes of word count
`define PULSE_ADDR   16'h0030   // any write fires one pulse

// ####################################################################
// widths
// ####################################################################

`define SRAM_ADDR_WIDTH 20
`define WORD_WIDTH      32

`endif

// File: src/sram_test_pkg.sv
package sram_test_pkg;

    // sram FIFO sequencer, one SRAM access per state
    typedef enum logic [2:0] {
        idle,
        write_lo,
        write_hi,
        read_fetch,
        read_latch
    } fifo_state_e;

    // last owner of the arbiter grant
    typedef enum logic {
        counter_src,
        pattern_src
    } arb_owner_e;

    typedef enum logic [1:0] {
        bus_idle,
        bus_read,
        bus_write
    } bus_op_e;

endpackage

// File: src/test_counters.sv
`timescale 1ns/1ps
`include "sram_test_defines.svh"

module test_counters (
    input  logic                   BUS_CLK,
    input  logic                   BUS_RST,
    input  logic                   counter_en,
    input  logic                   pulse,
    input  logic                   cnt_grant,
    input  logic                   usb_read,
    input  logic                   counter_direct,
    input  logic [7:0]             fifo_byte,
    output logic                   cnt_req,
    output logic [`WORD_WIDTH-1:0] cnt_data,
    output logic [7:0]             fd
);

    logic [31:0] c;
    logic [7:0]  base;
    logic [7:0]  direct_cnt;

    assign cnt_req = counter_en | pulse;

    // only the low byte of 4c shows up in the word
    assign base     = {c[5:0], 2'b00};
    assign cnt_data = {base + 8'd3, base + 8'd2, base + 8'd1, base};

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            c          <= '0;
            direct_cnt <= 8'h00;
        end else begin
            if (cnt_grant)
                c <= c + 32'd1;
            if (usb_read)
                direct_cnt <= direct_cnt + 8'd1;   // counts every strobe, valid byte or not
        end
    end

    assign fd = counter_direct ? direct_cnt : fifo_byte;

endmodule
